// ==== Bender.yml ====
package:
  name: dac_subsystem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dac_pkg.sv
      - rtl/dac_mmi_regs.sv
      - rtl/dac_update_ctrl.sv
      - rtl/dac_spi_master.sv
      - rtl/dac_subsystem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/dac_checker.sv
      - verif/dac_subsystem_tb.sv

// ==== project.f ====
+incdir+rtl
rtl/dac_pkg.sv
rtl/dac_mmi_regs.sv
rtl/dac_update_ctrl.sv
rtl/dac_spi_master.sv
rtl/dac_subsystem_top.sv
verif/dac_checker.sv
verif/dac_subsystem_tb.sv

// ==== rtl/dac_cfg.svh ====
//////////////////////////////////////////////////
// register addresses are word addresses on the bus
// the gain field has to sit below the power-down bits
//////////////////////////////////////////////////
`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

// register bus widths
`define DAC_DATA_W          16
`define DAC_ADDR_W          15

// reset word and version constant
`define DAC_DEFAULT         16'd100
`define DAC_MODULE_VERSION  16'd1

// address map
`define DAC_ADDR_VERSION    0
`define DAC_ADDR_DAC_REG    1
`define DAC_ADDR_EN_MMI     2
`define DAC_NUM_REGS        3

// gain field inside the DAC word
`define DAC_GAIN_LSB        6
`define DAC_GAIN_W          8

// system clocks per SPI half period, 1 or more
`define DAC_SPI_CLK_DIV     4

`endif

// ==== rtl/dac_mmi_regs.sv ====
//////////////////////////////////////////////////
// reads answer one cycle after rreq and writes are never stalled
// en_mmi_ctrl decides whether the bus or the gain strobe owns the DAC word
//////////////////////////////////////////////////
`include "dac_cfg.svh"

module dac_mmi_regs
    import dac_pkg::*;
(
    input  logic       clk,
    input  logic       SET_DEFAULT_ON_RESET,
    input  logic       en_mmi_ctrl,
    input  logic       wvalid,
    output logic       wready,
    input  reg_addr_t  waddr,
    input  reg_data_t  wdata,
    input  logic       rreq,
    input  reg_addr_t  raddr,
    output logic       rvalid,
    output reg_data_t  rdata,
    input  dac_gain_t  dac_reg,
    input  logic       dac_reg_valid_stb,
    output dac_word_t  dac_word,
    output logic       dac_changed
);

    localparam reg_addr_t ADDR_VERSION = reg_addr_t'(`DAC_ADDR_VERSION);
    localparam reg_addr_t ADDR_DAC_REG = reg_addr_t'(`DAC_ADDR_DAC_REG);
    localparam reg_addr_t ADDR_EN_MMI  = reg_addr_t'(`DAC_ADDR_EN_MMI);
    localparam reg_addr_t NUM_REGS     = reg_addr_t'(`DAC_NUM_REGS);

    dac_word_t dac_q;
    logic      en_mmi_q;
    logic      bus_wr;
    logic      gain_wr;
    reg_data_t rd_mux;

    assign dac_word = dac_q;

    // only one source can own the register at a time
    assign bus_wr  = wvalid && wready && en_mmi_ctrl && (waddr == ADDR_DAC_REG);
    assign gain_wr = dac_reg_valid_stb && !en_mmi_ctrl;

    //////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            wready      <= 1'b0;
            dac_q       <= `DAC_DEFAULT;
            dac_changed <= 1'b0;
            en_mmi_q    <= 1'b0;
        end else begin
            wready      <= 1'b1;
            en_mmi_q    <= en_mmi_ctrl;
            // pulse lines up with the new value on dac_word
            dac_changed <= bus_wr || gain_wr;
            if (bus_wr) begin
                dac_q <= dac_word_t'(wdata);
            end else if (gain_wr) begin
                // power-down bits and the unused tail stay as they are
                dac_q[`DAC_GAIN_LSB +: `DAC_GAIN_W] <= dac_reg;
            end
        end
    end

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////

    always_comb begin
        rd_mux = '0;
        // anything past the map reads as zero
        if (raddr < NUM_REGS) begin
            case (raddr)
                ADDR_VERSION: rd_mux = `DAC_MODULE_VERSION;
                ADDR_DAC_REG: rd_mux = reg_data_t'(dac_q);
                ADDR_EN_MMI:  rd_mux = reg_data_t'(en_mmi_q);
                default:      rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= rreq;
        end
    end

    // data only moves on a request
    always_ff @(posedge clk) begin
        if (rreq) begin
            rdata <= rd_mux;
        end
    end

    // every request is answered on the next cycle with a fully known word
    assert property (@(posedge clk) disable iff (SET_DEFAULT_ON_RESET)
        rreq |=> (rvalid && !$isunknown(rdata)));

endmodule

// ==== rtl/dac_pkg.sv ====
//////////////////////////////////////////////////
// types shared by the DAC control RTL and its testbench
//////////////////////////////////////////////////
`include "dac_cfg.svh"

package dac_pkg;

    // register bus payloads
    typedef logic [`DAC_DATA_W-1:0] reg_data_t;
    typedef logic [`DAC_ADDR_W-1:0] reg_addr_t;

    // bits 15:14 hold the power-down mode and bits 13:6 the gain code
    // low six bits are ignored by the converter
    typedef logic [15:0] dac_word_t;

    // direct gain code from the local loop
    typedef logic [`DAC_GAIN_W-1:0] dac_gain_t;

    // update sequencer
    typedef enum logic [1:0] {
        UPD_IDLE,
        UPD_START,
        UPD_BUSY
    } upd_state_t;

    // SPI serializer
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_END
    } spi_state_t;

endpackage

// ==== rtl/dac_spi_master.sv ====
//////////////////////////////////////////////////
// sclk idles low and mosi moves on its rising edge
// rdy stays low for 2 + 32 * DAC_SPI_CLK_DIV cycles per frame
//////////////////////////////////////////////////
`include "dac_cfg.svh"

module dac_spi_master
    import dac_pkg::*;
(
    input  logic       clk,
    input  logic       SET_DEFAULT_ON_RESET,
    input  logic       start_cmd,
    input  dac_word_t  tx_data,
    output logic       rdy,
    output logic       sclk,
    output logic       sync_n,
    output logic       mosi
);

    localparam int DIV       = `DAC_SPI_CLK_DIV;
    localparam int CNT_W     = $clog2(DIV + 1);
    localparam int FRAME_W   = $bits(dac_word_t);
    localparam int HALVES    = 2 * FRAME_W;
    localparam int HALF_W    = $clog2(HALVES);

    localparam logic [CNT_W-1:0]  DIV_LAST  = CNT_W'(DIV - 1);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(HALVES - 1);

    spi_state_t        state;
    logic [CNT_W-1:0]  div_cnt;
    logic [HALF_W-1:0] half_cnt;
    dac_word_t         shift_q;
    logic              half_done;

    assign half_done = (div_cnt == DIV_LAST);

    // MSB first straight out of the shift register
    assign mosi = shift_q[FRAME_W-1];

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            state    <= SPI_IDLE;
            rdy      <= 1'b1;
            sync_n   <= 1'b1;
            sclk     <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= '0;
            shift_q  <= '0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (start_cmd) begin
                        state    <= SPI_SHIFT;
                        rdy      <= 1'b0;
                        sync_n   <= 1'b0;
                        // first rising edge presents the MSB
                        sclk     <= 1'b1;
                        shift_q  <= tx_data;
                        div_cnt  <= '0;
                        half_cnt <= '0;
                    end
                end
                SPI_SHIFT: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        if (half_cnt == HALF_LAST) begin
                            // last low half done, sclk is already low
                            state  <= SPI_END;
                            sync_n <= 1'b1;
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                            sclk     <= ~sclk;
                            // odd halves are low, so this edge rises into the next bit
                            if (half_cnt[0]) begin
                                shift_q <= shift_q << 1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                SPI_END: begin
                    // two cycles with sync_n high before the next frame may start
                    if (div_cnt == CNT_W'(1)) begin
                        state <= SPI_IDLE;
                        rdy   <= 1'b1;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= SPI_IDLE;
                    rdy   <= 1'b1;
                end
            endcase
        end
    end

    // converter is never selected while a new command can be taken
    assert property (@(posedge clk) disable iff (SET_DEFAULT_ON_RESET)
        rdy |-> sync_n);

endmodule

// ==== rtl/dac_subsystem_top.sv ====
//////////////////////////////////////////////////
// one converter on one slave select
//////////////////////////////////////////////////

module dac_subsystem_top
    import dac_pkg::*;
(
    input  logic       clk,
    input  logic       SET_DEFAULT_ON_RESET,
    input  logic       en_mmi_ctrl,
    input  logic       wvalid,
    output logic       wready,
    input  reg_addr_t  waddr,
    input  reg_data_t  wdata,
    input  logic       rreq,
    input  reg_addr_t  raddr,
    output logic       rvalid,
    output reg_data_t  rdata,
    input  dac_gain_t  dac_reg,
    input  logic       dac_reg_valid_stb,
    output logic       dac_reg_updated_stb,
    output logic       sclk,
    output logic       sync_n,
    output logic       mosi
);

    // register map to sequencer
    dac_word_t dac_word;
    logic      dac_changed;

    // sequencer to serializer
    logic      start_cmd;
    dac_word_t tx_data;
    logic      rdy;

    dac_mmi_regs u_regs (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .wvalid               (wvalid),
        .wready               (wready),
        .waddr                (waddr),
        .wdata                (wdata),
        .rreq                 (rreq),
        .raddr                (raddr),
        .rvalid               (rvalid),
        .rdata                (rdata),
        .dac_reg              (dac_reg),
        .dac_reg_valid_stb    (dac_reg_valid_stb),
        .dac_word             (dac_word),
        .dac_changed          (dac_changed)
    );

    dac_update_ctrl u_ctrl (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .dac_word             (dac_word),
        .dac_changed          (dac_changed),
        .rdy                  (rdy),
        .start_cmd            (start_cmd),
        .tx_data              (tx_data),
        .dac_reg_updated_stb  (dac_reg_updated_stb)
    );

    dac_spi_master u_spi (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .start_cmd            (start_cmd),
        .tx_data              (tx_data),
        .rdy                  (rdy),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .mosi                 (mosi)
    );

endmodule

// ==== rtl/dac_update_ctrl.sv ====
//////////////////////////////////////////////////
// changes during a frame merge into one follow-up frame
// the frame after reset carries whatever dac_word holds then
//////////////////////////////////////////////////

module dac_update_ctrl
    import dac_pkg::*;
(
    input  logic       clk,
    input  logic       SET_DEFAULT_ON_RESET,
    input  dac_word_t  dac_word,
    input  logic       dac_changed,
    input  logic       rdy,
    output logic       start_cmd,
    output dac_word_t  tx_data,
    output logic       dac_reg_updated_stb
);

    upd_state_t state;
    logic       pending;
    logic       rdy_q;
    logic       want_frame;
    logic       load;

    // a change right now or one held back during the last frame
    assign want_frame = dac_changed || pending;

    // new request either from idle or straight off the end of a frame
    assign load = want_frame &&
                  ((state == UPD_IDLE) || ((state == UPD_BUSY) && rdy));

    //////////////////////////////////////////////////
    // request FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            state     <= UPD_IDLE;
            start_cmd <= 1'b0;
            // one frame is owed so the default word goes out after reset
            pending   <= 1'b1;
        end else begin
            case (state)
                UPD_IDLE: begin
                    if (load) begin
                        state     <= UPD_START;
                        start_cmd <= 1'b1;
                        pending   <= 1'b0;
                    end
                end
                UPD_START: begin
                    // serializer has the word once rdy drops
                    if (!rdy) begin
                        state     <= UPD_BUSY;
                        start_cmd <= 1'b0;
                    end
                    // tx_data is already committed, so remember the change
                    if (dac_changed) begin
                        pending <= 1'b1;
                    end
                end
                UPD_BUSY: begin
                    if (rdy) begin
                        if (load) begin
                            state     <= UPD_START;
                            start_cmd <= 1'b1;
                            pending   <= 1'b0;
                        end else begin
                            state <= UPD_IDLE;
                        end
                    end else if (dac_changed) begin
                        pending <= 1'b1;
                    end
                end
                default: begin
                    state     <= UPD_IDLE;
                    start_cmd <= 1'b0;
                end
            endcase
        end
    end

    // newest register value at the moment of the request
    always_ff @(posedge clk) begin
        if (load) begin
            tx_data <= dac_word;
        end
    end

    //////////////////////////////////////////////////
    // frame done strobe
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            rdy_q               <= 1'b1;
            dac_reg_updated_stb <= 1'b0;
        end else begin
            rdy_q               <= rdy;
            dac_reg_updated_stb <= rdy && !rdy_q;
        end
    end

    // the serializer latches the word on the edge after this cycle
    assert property (@(posedge clk) disable iff (SET_DEFAULT_ON_RESET)
        (start_cmd && rdy) |=> $stable(tx_data));

    // a request is only withdrawn once the serializer has taken it
    assert property (@(posedge clk) disable iff (SET_DEFAULT_ON_RESET)
        $fell(start_cmd) |-> $past(!rdy));

endmodule

// ==== verif/dac_checker.sv ====
//////////////////////////////////////////////////
// frames are decoded on the sclk falling edge while sync_n is low
// the last frame is compared once the line has been quiet for a frame time
//////////////////////////////////////////////////
`include "dac_cfg.svh"

module dac_checker
    import dac_pkg::*;
(
    input  logic       clk,
    input  logic       SET_DEFAULT_ON_RESET,
    input  logic       en_mmi_ctrl,
    input  logic       wvalid,
    input  logic       wready,
    input  reg_addr_t  waddr,
    input  reg_data_t  wdata,
    input  logic       rreq,
    input  reg_addr_t  raddr,
    input  logic       rvalid,
    input  reg_data_t  rdata,
    input  dac_gain_t  dac_reg,
    input  logic       dac_reg_valid_stb,
    input  logic       dac_reg_updated_stb,
    input  logic       sclk,
    input  logic       sync_n,
    input  logic       mosi,
    input  logic       final_check,
    output int         err_count,
    output int         check_count,
    output int         frame_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDLE_CYC = 2 + 32 * `DAC_SPI_CLK_DIV;

    string     test_name = "none";
    dac_word_t model_dac;
    logic      model_en;
    logic      wr_ready_exp;
    dac_word_t next_dac;
    dac_word_t hist[$];
    dac_word_t allowed[$];
    dac_word_t shreg;
    dac_word_t last_frame;
    reg_data_t rd_exp;
    logic      rd_pending;
    logic      sclk_q;
    logic      sync_q;
    logic      final_q;
    int        bits;
    int        idle_cnt;
    int        change_count;
    int        stb_count;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("%s: %s", test_name, msg);
    endtask

    // address map as seen from the bus
    function automatic reg_data_t expected_read(input reg_addr_t addr);
        case (addr)
            `DAC_ADDR_VERSION: return `DAC_MODULE_VERSION;
            `DAC_ADDR_DAC_REG: return model_dac;
            `DAC_ADDR_EN_MMI:  return {15'd0, model_en};
            default:           return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        logic changed;
        logic hit;
        if (SET_DEFAULT_ON_RESET) begin
            model_dac    = `DAC_DEFAULT;
            model_en     = 1'b0;
            wr_ready_exp = 1'b0;
            hist         = {`DAC_DEFAULT};
            rd_pending   = 1'b0;
            sclk_q       = 1'b0;
            sync_q       = 1'b1;
            final_q      = 1'b0;
            bits         = 0;
            idle_cnt     = 0;
        end else begin
            // write side is never stalled once out of reset
            check_value("wready", wr_ready_exp, wready);

            //////////////////////////////////////////////////
            // read responses
            //////////////////////////////////////////////////
            if (rd_pending) begin
                if (!rvalid) begin
                    report_error("rvalid missing one cycle after rreq");
                end else begin
                    check_value("read", rd_exp, rdata);
                end
            end else if (rvalid) begin
                report_error("rvalid without a read request");
            end
            rd_pending = rreq;
            rd_exp     = expected_read(raddr);

            //////////////////////////////////////////////////
            // frame decode at the pins
            //////////////////////////////////////////////////
            if (sync_q && !sync_n) begin
                // anything held since the previous frame began may go out now
                allowed = hist;
                hist    = {model_dac};
                bits    = 0;
            end
            if (!sync_n && sclk_q && !sclk) begin
                shreg = {shreg[14:0], mosi};
                bits++;
            end
            if (!sync_q && sync_n) begin
                if (bits != 16) begin
                    report_error($sformatf("frame carried %0d bits instead of 16", bits));
                end
                if (frame_count == 0) begin
                    check_value("first frame", `DAC_DEFAULT, shreg);
                end
                hit = 1'b0;
                foreach (allowed[i]) begin
                    if (allowed[i] == shreg) begin
                        hit = 1'b1;
                    end
                end
                if (hit) begin
                    check_count++;
                end else begin
                    check_value("frame", allowed[$], shreg);
                end
                last_frame = shreg;
                frame_count++;
            end

            //////////////////////////////////////////////////
            // register model
            //////////////////////////////////////////////////
            changed  = 1'b0;
            next_dac = model_dac;
            if (wvalid && wr_ready_exp && en_mmi_ctrl && (waddr == `DAC_ADDR_DAC_REG)) begin
                next_dac = wdata;
                changed  = 1'b1;
            end else if (dac_reg_valid_stb && !en_mmi_ctrl) begin
                next_dac[13:6] = dac_reg;
                changed        = 1'b1;
            end
            if (changed) begin
                model_dac = next_dac;
                hist.push_back(next_dac);
                change_count++;
            end
            model_en = en_mmi_ctrl;
            if (dac_reg_updated_stb) begin
                stb_count++;
            end

            // quiet line means the newest value must be on the converter
            if (changed || !sync_n) begin
                idle_cnt = 0;
            end else if (idle_cnt < IDLE_CYC) begin
                idle_cnt++;
                if ((idle_cnt == IDLE_CYC) && (frame_count > 0)) begin
                    check_value("settled frame", model_dac, last_frame);
                end
            end

            if (final_check && !final_q) begin
                check_value("done strobes", frame_count, stb_count);
                if (frame_count > change_count + 1) begin
                    report_error($sformatf("%0d frames for only %0d changes",
                                           frame_count, change_count));
                end
            end
            final_q      = final_check;
            sclk_q       = sclk;
            sync_q       = sync_n;
            wr_ready_exp = 1'b1;
        end
    end

endmodule

// ==== verif/dac_subsystem_tb.sv ====
//////////////////////////////////////////////////
// stimulus moves on the falling edge and the checker judges every result
//////////////////////////////////////////////////
`include "dac_cfg.svh"

module dac_subsystem_tb
    import dac_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'hca65_1fda;
    localparam int N_READS     = 40;
    localparam int N_WRITES    = 20;
    localparam int N_GAIN      = 20;
    localparam int N_BURST     = 24;
    localparam int FRAME_CYC   = 2 + 32 * `DAC_SPI_CLK_DIV + 8;
    localparam int TOTAL_OPS   = 3 + N_READS + (N_WRITES + 2) + (2 * N_GAIN + 4)
                                 + (N_BURST + 4) + 1;
    localparam int CYCLE_LIMIT = TOTAL_OPS * FRAME_CYC + 2000;

    logic       clk;
    logic       SET_DEFAULT_ON_RESET;
    logic       en_mmi_ctrl;
    logic       wvalid;
    logic       wready;
    reg_addr_t  waddr;
    reg_data_t  wdata;
    logic       rreq;
    reg_addr_t  raddr;
    logic       rvalid;
    reg_data_t  rdata;
    dac_gain_t  dac_reg;
    logic       dac_reg_valid_stb;
    logic       dac_reg_updated_stb;
    logic       sclk;
    logic       sync_n;
    logic       mosi;
    logic       final_check;
    int         err_count;
    int         check_count;
    int         frame_count;
    int         seed_val;
    int         cycle_cnt;
    int         test_count;
    int         errs_before;
    int         other;
    string      cur_test;

    dac_subsystem_top u_dac_subsystem_top (
        .clk(clk), .SET_DEFAULT_ON_RESET(SET_DEFAULT_ON_RESET), .en_mmi_ctrl(en_mmi_ctrl),
        .wvalid(wvalid), .wready(wready), .waddr(waddr), .wdata(wdata),
        .rreq(rreq), .raddr(raddr), .rvalid(rvalid), .rdata(rdata),
        .dac_reg(dac_reg), .dac_reg_valid_stb(dac_reg_valid_stb),
        .dac_reg_updated_stb(dac_reg_updated_stb), .sclk(sclk), .sync_n(sync_n), .mosi(mosi)
    );

    dac_checker u_checker (
        .clk(clk), .SET_DEFAULT_ON_RESET(SET_DEFAULT_ON_RESET), .en_mmi_ctrl(en_mmi_ctrl),
        .wvalid(wvalid), .wready(wready), .waddr(waddr), .wdata(wdata),
        .rreq(rreq), .raddr(raddr), .rvalid(rvalid), .rdata(rdata),
        .dac_reg(dac_reg), .dac_reg_valid_stb(dac_reg_valid_stb),
        .dac_reg_updated_stb(dac_reg_updated_stb), .sclk(sclk), .sync_n(sync_n), .mosi(mosi),
        .final_check(final_check), .err_count(err_count), .check_count(check_count),
        .frame_count(frame_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run timed out after %0d cycles", cycle_cnt);
        $display("Test FAILED");
        $finish;
    end

    task automatic begin_test(input string name);
        cur_test = name;
        u_checker.test_name = name;
        errs_before = err_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("%s finished with %0d errors", cur_test, err_count - errs_before);
    endtask

    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        @(negedge clk);
        wvalid = 1'b1;
        waddr  = addr;
        wdata  = data;
        // held until an edge with wready high takes it
        while (!wready) begin
            @(negedge clk);
        end
        @(negedge clk);
        wvalid = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr);
        @(negedge clk);
        rreq  = 1'b1;
        raddr = addr;
        @(negedge clk);
        rreq  = 1'b0;
    endtask

    task automatic gain_strobe(input dac_gain_t code);
        @(negedge clk);
        dac_reg           = code;
        dac_reg_valid_stb = 1'b1;
        @(negedge clk);
        dac_reg_valid_stb = 1'b0;
    endtask

    task automatic wait_frame_done();
        @(negedge clk);
        while (!dac_reg_updated_stb) begin
            @(negedge clk);
        end
    endtask

    // line quiet for a little over one frame
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < FRAME_CYC + 16) begin
            @(negedge clk);
            if (sync_n && !dac_reg_updated_stb) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        SET_DEFAULT_ON_RESET = 1'b1;
        en_mmi_ctrl          = 1'b1;
        wvalid               = 1'b0;
        waddr                = '0;
        wdata                = '0;
        rreq                 = 1'b0;
        raddr                = '0;
        dac_reg              = '0;
        dac_reg_valid_stb    = 1'b0;
        final_check          = 1'b0;
        test_count           = 0;
        seed_val             = $urandom(SEED);
        repeat (4) @(posedge clk);
        @(negedge clk);
        SET_DEFAULT_ON_RESET = 1'b0;

        begin_test("reset_default");
        wait_frame_done();
        bus_read(`DAC_ADDR_DAC_REG);
        wait_idle();
        end_test();

        begin_test("random_reads");
        for (int i = 0; i < N_READS; i++) begin
            @(negedge clk);
            en_mmi_ctrl = $urandom % 2;
            bus_read($urandom % 6);
        end
        end_test();

        begin_test("bus_writes");
        @(negedge clk);
        en_mmi_ctrl = 1'b1;
        for (int i = 0; i < N_WRITES; i++) begin
            if ($urandom % 4 != 0) begin
                bus_write(`DAC_ADDR_DAC_REG, $urandom);
                wait_frame_done();
            end else begin
                // any address except the DAC register
                other = $urandom % 5;
                if (other >= `DAC_ADDR_DAC_REG) begin
                    other++;
                end
                bus_write(other, $urandom);
                bus_read(`DAC_ADDR_DAC_REG);
            end
        end
        bus_read(`DAC_ADDR_DAC_REG);
        wait_idle();
        end_test();

        begin_test("gain_strobes");
        @(negedge clk);
        en_mmi_ctrl = 1'b0;
        for (int i = 0; i < N_GAIN; i++) begin
            gain_strobe($urandom);
            wait_frame_done();
            bus_write(`DAC_ADDR_DAC_REG, $urandom);
            bus_read(`DAC_ADDR_DAC_REG);
        end
        @(negedge clk);
        en_mmi_ctrl = 1'b1;
        repeat (4) gain_strobe($urandom);
        bus_read(`DAC_ADDR_DAC_REG);
        wait_idle();
        end_test();

        begin_test("update_burst");
        for (int i = 0; i < N_BURST; i++) begin
            if (i == N_BURST / 2) begin
                @(negedge clk);
                en_mmi_ctrl = 1'b0;
            end
            if (en_mmi_ctrl) begin
                bus_write(`DAC_ADDR_DAC_REG, $urandom);
            end else begin
                gain_strobe($urandom);
            end
            idle_cycles(1 + $urandom % 40);
        end
        wait_idle();
        bus_read(`DAC_ADDR_DAC_REG);
        end_test();

        begin_test("strobe_count");
        @(negedge clk);
        final_check = 1'b1;
        @(negedge clk);
        final_check = 1'b0;
        @(negedge clk);
        end_test();

        $display("tests %0d, checks %0d, frames %0d, errors %0d",
                 test_count, check_count, frame_count, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
